// File: rtl/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // default cache geometry.
    localparam int ways_dflt = 2;
    localparam int sets_dflt = 64;
    localparam int line_words_dflt = 4; // 32-bit words per line.

    // axi defaults.
    localparam int addr_len_dflt = 32;
    localparam int id_len_dflt = 2;

    // derived widths.
    localparam int word_idx_w = $clog2(sets_dflt * line_words_dflt);
    localparam int way_w = (ways_dflt > 1) ? $clog2(ways_dflt) : 1;

    // lines per bank and bank count are fixed by the word index lsb.
    localparam int banks = 2;

endpackage

// File: rtl/cache_types_pkg.sv
package cache_types_pkg;

    import cache_cfg_pkg::*;

    // one write into the data array, from the core or the fill engine.
    typedef struct packed {
        logic ce;
        logic [3:0] wm;                 // byte mask within the word.
        logic [way_w-1:0] way;
        logic [word_idx_w-1:0] word_idx;
        logic [31:0] data;
    } cache_wr_t;

    // one read of all ways at a word index.
    typedef struct packed {
        logic re;
        logic [word_idx_w-1:0] word_idx;
    } cache_rd_t;

    // line fetch request, valid and ready travel beside it.
    typedef struct packed {
        logic [addr_len_dflt-1:0] line_addr; // byte address of line base.
        logic [way_w-1:0] way;
    } fill_req_t;

    // bank of a word index.
    function automatic logic [$clog2(banks)-1:0] bank_of(
        input logic [word_idx_w-1:0] word_idx
    );
        return word_idx[$clog2(banks)-1:0];
    endfunction

endpackage

// File: rtl/cache_sram.sv
`timescale 1ns/100ps

module cache_sram #(
    parameter int width = 64,
    parameter int depth = 128
) (
    input  logic                     clk,

    // read/write port.
    input  logic                     we,
    input  logic [width/8-1:0]       wm,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [width-1:0]         wdata,

    // read-only port.
    input  logic                     re,
    input  logic [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]         rdata
);

    localparam int bytes = width / 8;

    logic [width-1:0] mem [depth];
    logic [width-1:0] rd_q;

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < bytes; b++) begin
                if (wm[b]) begin
                    mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // array access happens in the request's own edge, so a same-cycle
    // write is not seen by the read.
    always_ff @(posedge clk) begin
        if (re) begin
            rd_q <= mem[raddr];
        end
    end

    always_ff @(posedge clk) begin
        rdata <= rd_q; // output stage.
    end

endmodule

// File: rtl/dcache_banks.sv
`timescale 1ns/100ps

module dcache_banks
    import cache_types_pkg::*;
#(
    parameter int ways = 2,
    parameter int sets = 64,
    parameter int line_words = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  cache_wr_t            fill_wr,
    input  cache_wr_t            core_wr,
    input  cache_rd_t            core_rd,

    output logic                 wbusy,
    output logic [ways-1:0][31:0] rd_data,
    output logic                 rd_valid
);

    localparam int words = sets * line_words;
    localparam int idx_w = $clog2(words);
    localparam int bank_depth = words / 2;
    localparam int row_w = 32 * ways;
    localparam int wm_w = 4 * ways;

    logic [ways-1:0][31:0] bank_rd [2];
    logic [1:0] re_q;
    logic [1:0] bank_q;

    // fill and core collide on the same bank, fill wins.
    assign wbusy = fill_wr.ce && core_wr.ce &&
                   (bank_of(fill_wr.word_idx) == bank_of(core_wr.word_idx));

    for (genvar b = 0; b < 2; b++) begin : g_bank
        localparam bit bank_id = (b != 0);

        logic fill_hit;
        logic core_hit;
        cache_wr_t sel;
        logic [wm_w-1:0] lane_wm;

        assign fill_hit = fill_wr.ce && (bank_of(fill_wr.word_idx) == bank_id);
        assign core_hit = core_wr.ce && !wbusy && (bank_of(core_wr.word_idx) == bank_id);
        assign sel = fill_hit ? fill_wr : core_wr;

        // byte mask moved into the lane of the chosen way.
        assign lane_wm = wm_w'(sel.wm) << (4 * sel.way);

        cache_sram #(
            .width(row_w),
            .depth(bank_depth)
        ) sram_inst (
            .clk(clk),
            .we(fill_hit || core_hit),
            .wm(lane_wm),
            .waddr(sel.word_idx[idx_w-1:1]),
            .wdata({ways{sel.data}}),
            .re(core_rd.re && (bank_of(core_rd.word_idx) == bank_id)),
            .raddr(core_rd.word_idx[idx_w-1:1]),
            .rdata(bank_rd[b])
        );
    end

    // bank select and valid follow the two-cycle read.
    always_ff @(posedge clk) begin
        if (rst) begin
            re_q <= '0;
        end else begin
            re_q <= {re_q[0], core_rd.re};
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= {bank_q[0], bank_of(core_rd.word_idx)};
    end

    assign rd_valid = re_q[1];
    assign rd_data = bank_rd[bank_q[1]];

endmodule

// File: rtl/line_fill_ctrl.sv
`timescale 1ns/100ps

module line_fill_ctrl
    import cache_types_pkg::*;
#(
    parameter int line_words = 4,
    parameter int addr_len = 32,
    parameter int id_len = 2,
    parameter int word_idx_w = 8,
    parameter int way_w = 1
) (
    input  logic                clk,
    input  logic                rst,

    // fill request.
    input  logic                fill_req_valid,
    input  fill_req_t           fill_req,
    output logic                fill_req_ready,
    output logic                fill_done,

    // write into the data array.
    output cache_wr_t           fill_wr,

    // axi read address.
    output logic [id_len-1:0]   arid,
    output logic [addr_len-1:0] araddr,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    output logic                arvalid,
    input  logic                arready,

    // axi read data.
    output logic                rready,
    input  logic [31:0]         rdata,
    input  logic                rlast,
    input  logic                rvalid
);

    localparam int beat_w = (line_words > 1) ? $clog2(line_words) : 1;
    localparam logic [2:0] size_word = 3'd2;
    localparam logic [1:0] burst_incr = 2'b01;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t state;
    logic [addr_len-1:0] line_addr_q;
    logic [way_w-1:0] way_q;
    logic [beat_w-1:0] beat;
    logic [word_idx_w-1:0] base_idx;
    logic beat_ok;

    assign fill_req_ready = (state == st_idle);
    assign beat_ok = (state == st_data) && rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            beat <= '0;
        end else begin
            case (state)
                st_idle: if (fill_req_valid) state <= st_addr;
                st_addr: if (arready) begin
                    state <= st_data;
                    beat <= '0;
                end
                st_data: if (rvalid) begin
                    beat <= beat + 1'b1;
                    if (rlast) state <= st_idle; // early rlast also ends it.
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_req_valid && fill_req_ready) begin
            line_addr_q <= fill_req.line_addr;
            way_q <= fill_req.way;
        end
    end

    assign arid = '0;
    assign araddr = line_addr_q;
    assign arlen = 8'(line_words - 1);
    assign arsize = size_word;
    assign arburst = burst_incr;
    assign arvalid = (state == st_addr);
    assign rready = (state == st_data);

    // word index of the line base.
    assign base_idx = line_addr_q[2 +: word_idx_w];

    always_comb begin
        fill_wr.ce = beat_ok;
        fill_wr.wm = 4'hf;
        fill_wr.way = way_q;
        fill_wr.word_idx = base_idx + word_idx_w'(beat);
        fill_wr.data = rdata;
    end

    assign fill_done = beat_ok && rlast;

endmodule

// File: rtl/cache_subsys.sv
`timescale 1ns/100ps

module cache_subsys
    import cache_cfg_pkg::*, cache_types_pkg::*;
#(
    parameter int ways = ways_dflt,
    parameter int sets = sets_dflt,
    parameter int line_words = line_words_dflt,
    parameter int addr_len = addr_len_dflt,
    parameter int id_len = id_len_dflt
) (
    input  logic                  clk,
    input  logic                  rst,

    // line fill request.
    input  logic                  fill_req_valid,
    input  fill_req_t             fill_req,
    output logic                  fill_req_ready,
    output logic                  fill_done,

    // core side.
    input  cache_wr_t             core_wr,
    input  cache_rd_t             core_rd,
    output logic                  wbusy,
    output logic [ways-1:0][31:0] rd_data,
    output logic                  rd_valid,

    // axi read address.
    output logic [id_len-1:0]     arid,
    output logic [addr_len-1:0]   araddr,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    output logic [1:0]            arburst,
    output logic                  arvalid,
    input  logic                  arready,

    // axi read data.
    output logic                  rready,
    input  logic [31:0]           rdata,
    input  logic                  rlast,
    input  logic                  rvalid
);

    localparam int idx_w = $clog2(sets * line_words);
    localparam int way_sel_w = (ways > 1) ? $clog2(ways) : 1;

    cache_wr_t fill_wr;

    line_fill_ctrl #(
        .line_words(line_words),
        .addr_len(addr_len),
        .id_len(id_len),
        .word_idx_w(idx_w),
        .way_w(way_sel_w)
    ) fill_inst (
        .clk(clk),
        .rst(rst),
        .fill_req_valid(fill_req_valid),
        .fill_req(fill_req),
        .fill_req_ready(fill_req_ready),
        .fill_done(fill_done),
        .fill_wr(fill_wr),
        .arid(arid),
        .araddr(araddr),
        .arlen(arlen),
        .arsize(arsize),
        .arburst(arburst),
        .arvalid(arvalid),
        .arready(arready),
        .rready(rready),
        .rdata(rdata),
        .rlast(rlast),
        .rvalid(rvalid)
    );

    dcache_banks #(
        .ways(ways),
        .sets(sets),
        .line_words(line_words)
    ) banks_inst (
        .clk(clk),
        .rst(rst),
        .fill_wr(fill_wr),
        .core_wr(core_wr),
        .core_rd(core_rd),
        .wbusy(wbusy),
        .rd_data(rd_data),
        .rd_valid(rd_valid)
    );

endmodule

// File: dv/cache_subsys_asserts.sv
`timescale 1ns/100ps

module cache_subsys_asserts (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic [7:0]  arlen,
    input logic [2:0]  arsize,
    input logic [1:0]  arburst,
    input logic        rready,
    input logic        rvalid,
    input logic        rlast,
    input logic        wbusy,
    input logic        fill_done
);

    logic outstanding; // burst accepted, last beat not yet seen.

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            outstanding <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) &&
            $stable(arsize) && $stable(arburst))
        else $error("ar channel changed while waiting for arready");

    r_outstanding: assert property (@(posedge clk) disable iff (rst)
        rready |-> outstanding)
        else $error("rready high with no burst outstanding");

    busy_needs_fill: assert property (@(posedge clk) disable iff (rst)
        wbusy |-> outstanding && rvalid && rready)
        else $error("wbusy high without a fill write");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        fill_done |=> !fill_done)
        else $error("fill_done held longer than one cycle");

endmodule

// File: dv/cache_subsys_tb.sv
`timescale 1ns/100ps

module cache_subsys_tb
    import cache_cfg_pkg::*, cache_types_pkg::*;
;

    localparam int fill_tests = 8;
    localparam int write_cycles = 200;
    localparam int conflict_fills = 6;
    localparam int mixed_cycles = 400;
    localparam int n_ops = fill_tests * 8 + write_cycles + conflict_fills + mixed_cycles;
    localparam int timeout_ns = n_ops * 40 * 2 * 4; // worst fill 40 cycles, margin 2.

    logic clk = 1'b0;
    logic rst;
    logic fill_req_valid, fill_req_ready, fill_done;
    fill_req_t fill_req;
    cache_wr_t core_wr;
    cache_rd_t core_rd;
    logic wbusy, rd_valid;
    logic [1:0][31:0] rd_data;
    logic [1:0] arid;
    logic [31:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid, arready, rready, rlast, rvalid;
    logic [31:0] rdata;

    logic [15:0] lfsr = 16'd28;
    logic [31:0] ext_mem [1024];
    logic [31:0] model [2][256];
    logic [3:0] known [2][256]; // bytes whose contents are defined.
    int exp_due[$];
    logic [63:0] exp_data[$];
    logic [63:0] exp_mask[$];
    int cyc = 0;
    logic accept_seen = 1'b0;
    logic [1:0] fill_phase = 2'd0; // 0 idle, 1 address, 2 data.
    logic [31:0] fill_addr_q;
    logic fill_way_q;
    int fill_beat_q;
    int fills_done = 0;
    int fills_accepted = 0;
    logic [2:0] last_line;

    // axi slave state, sampled on the falling edge.
    logic ar_hs_s, arv_s, r_hs_s;
    logic [31:0] araddr_s, s_addr;
    logic busy = 1'b0;
    int s_beat;

    cache_subsys cache_subsys_inst (.*);

    bind cache_subsys cache_subsys_asserts asserts_inst (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .rready(rready), .rvalid(rvalid), .rlast(rlast), .wbusy(wbusy),
        .fill_done(fill_done)
    );

    always #2 clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11.
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function logic [31:0] byte_mask(input logic [3:0] m);
        logic [31:0] bm;
        for (int b = 0; b < 4; b++) begin
            bm[b*8 +: 8] = {8{m[b]}};
        end
        return bm;
    endfunction

    function void write_model(input logic w, input logic [7:0] i, input logic [3:0] wm,
                              input logic [31:0] d);
        logic [31:0] bm;
        bm = byte_mask(wm);
        model[w][i] = (model[w][i] & ~bm) | (d & bm);
        known[w][i] = known[w][i] | wm;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // axi read slave with random gaps.
    always @(negedge clk) begin
        ar_hs_s = arvalid && arready;
        arv_s = arvalid;
        r_hs_s = rvalid && rready;
        araddr_s = araddr;
    end

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            busy = 1'b0;
            s_beat = 0;
        end else begin
            if (r_hs_s) begin
                if (s_beat == 3) busy = 1'b0;
                s_beat++;
            end
            if (ar_hs_s) begin
                busy = 1'b1;
                s_addr = araddr_s;
                s_beat = 0;
                arready <= 1'b0;
            end else begin
                arready <= arv_s && !busy && (rand_bits(2) != 0);
            end
            if (busy && !ar_hs_s && (rand_bits(2) != 0)) begin
                rvalid <= 1'b1;
                rdata <= ext_mem[s_addr[11:2] + 10'(s_beat)];
                rlast <= (s_beat == 3);
            end else begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
            end
        end
    end

    // checks against the reference model, on the falling edge.
    always @(negedge clk) begin : monitor
        logic fill_act;
        logic exp_busy;
        logic [7:0] fidx;
        logic [7:0] ridx;
        logic [63:0] e;
        logic [63:0] m;
        if (!rst) begin
            check_val("fill_req_ready", 64'(fill_req_ready), 64'(fill_phase == 2'd0));
            check_val("arvalid", 64'(arvalid), 64'(fill_phase == 2'd1));
            check_val("rready", 64'(rready), 64'(fill_phase == 2'd2));
            accept_seen = fill_req_valid && fill_req_ready;
            if (accept_seen) begin
                fill_addr_q = fill_req.line_addr;
                fill_way_q = fill_req.way;
                fill_beat_q = 0;
                fill_phase = 2'd1;
                fills_accepted++;
            end
            if (arvalid) begin
                check_val("araddr", 64'(araddr), 64'(fill_addr_q));
                check_val("arlen", 64'(arlen), 64'(3));
                check_val("arsize", 64'(arsize), 64'(2));
                check_val("arburst", 64'(arburst), 64'(1));
                check_val("arid", 64'(arid), 64'(0));
                if (arready) fill_phase = 2'd2;
            end
            fill_act = rvalid && rready;
            fidx = {fill_addr_q[9:4], 2'(fill_beat_q)};
            exp_busy = fill_act && core_wr.ce && (fidx[0] == core_wr.word_idx[0]);
            check_val("wbusy", 64'(wbusy), 64'(exp_busy));
            check_val("fill_done", 64'(fill_done), 64'(fill_act && fill_beat_q == 3));
            if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                check_val("rd_valid", 64'(rd_valid), 64'(1));
                check_val("rd_data", rd_data & exp_mask[0], exp_data[0] & exp_mask[0]);
                void'(exp_due.pop_front());
                void'(exp_data.pop_front());
                void'(exp_mask.pop_front());
            end else begin
                check_val("rd_valid", 64'(rd_valid), 64'(0));
            end
            if (core_rd.re) begin // old contents, before this edge's writes.
                ridx = core_rd.word_idx;
                for (int w = 0; w < 2; w++) begin
                    e[w*32 +: 32] = model[w][ridx];
                    m[w*32 +: 32] = byte_mask(known[w][ridx]);
                end
                exp_due.push_back(cyc + 2);
                exp_data.push_back(e);
                exp_mask.push_back(m);
            end
            if (fill_act) begin
                write_model(fill_way_q, fidx, 4'hf,
                            ext_mem[fill_addr_q[11:2] + 10'(fill_beat_q)]);
                if (fill_beat_q == 3) begin
                    fills_done++;
                    fill_phase = 2'd0;
                end
                fill_beat_q++;
            end
            if (core_wr.ce && !exp_busy) begin
                write_model(core_wr.way, core_wr.word_idx, core_wr.wm, core_wr.data);
            end
        end
        cyc++;
    end

    task automatic step(input bit wr_en, input bit rd_en, input bit fill_en, input int rd_sel);
        cache_wr_t w;
        cache_rd_t r;
        fill_req_t f;
        @(posedge clk);
        if (fill_req_valid && accept_seen) begin
            fill_req_valid <= 1'b0;
        end else if (!fill_req_valid && fill_en) begin
            f.line_addr = {20'(rand_bits(20)), 2'(rand_bits(2)), 3'b000, 3'(rand_bits(3)),
                           4'h0};
            f.way = 1'(rand_bits(1));
            fill_req <= f;
            fill_req_valid <= 1'b1;
            last_line <= f.line_addr[6:4];
        end
        w = '0;
        if (wr_en) begin
            w.ce = 1'b1;
            w.wm = 4'(rand_bits(4));
            w.way = 1'(rand_bits(1));
            w.word_idx = 8'(rand_bits(5)); // first eight lines only.
            w.data = rand_bits(32);
        end
        core_wr <= w;
        r.re = rd_en;
        r.word_idx = (rd_sel < 0) ? 8'(rand_bits(5)) : 8'(rd_sel);
        core_rd <= r;
    endtask

    task automatic run_fill(input bit wr_during);
        int target;
        int waited;
        target = fills_done + 1;
        waited = 0;
        step(1'b0, 1'b0, 1'b1, -1);
        while (fills_done < target) begin
            step(wr_during, 1'b0, 1'b0, -1);
            waited++;
            if (waited > 200) fail_now("fill_done never arrived");
        end
    endtask

    task automatic read_line();
        for (int k = 0; k < 4; k++) begin
            step(1'b0, 1'b1, 1'b0, int'({last_line, 2'(k)}));
        end
        repeat (3) step(1'b0, 1'b0, 1'b0, -1);
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        fill_req_valid = 1'b0;
        fill_req = '0;
        core_wr = '0;
        core_rd = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        for (int i = 0; i < 1024; i++) ext_mem[i] = rand_bits(32);
        for (int i = 0; i < 256; i++) begin
            for (int w = 0; w < 2; w++) begin
                model[w][i] = '0;
                known[w][i] = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("arvalid", 64'(arvalid), 64'(0));
        check_val("rready", 64'(rready), 64'(0));
        check_val("rd_valid", 64'(rd_valid), 64'(0));
        check_val("fill_done", 64'(fill_done), 64'(0));
        check_val("fill_req_ready", 64'(fill_req_ready), 64'(1));

        repeat (fill_tests) begin
            run_fill(1'b0);
            read_line();
        end
        repeat (write_cycles) step(1'(rand_bits(1)), 1'(rand_bits(1)), 1'b0, -1);
        repeat (conflict_fills) begin
            run_fill(1'b1); // core writes race the fill.
            read_line();
        end
        repeat (mixed_cycles) begin
            step(1'(rand_bits(1)), 1'(rand_bits(1)), rand_bits(3) == 0, -1);
        end

        waited = 0;
        while (fill_req_valid || fills_done < fills_accepted) begin
            step(1'b0, 1'b0, 1'b0, -1);
            waited++;
            if (waited > 200) fail_now("last fill did not complete");
        end
        repeat (4) step(1'b0, 1'b0, 1'b0, -1);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(timeout_ns);
        fail_now("watchdog expired before the tests finished");
    end

endmodule

// File: flist.f
rtl/cache_cfg_pkg.sv
rtl/cache_types_pkg.sv
rtl/cache_sram.sv
rtl/dcache_banks.sv
rtl/line_fill_ctrl.sv
rtl/cache_subsys.sv
dv/cache_subsys_asserts.sv
dv/cache_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cache_subsys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation with $(VERILATOR)"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
